// ==== hw/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // add also covers addu and the address sum, sub covers the branch compare
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_e;

    ////////////////////////////////////////
    // control bundle and memory request
    ////////////////////////////////////////
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    shamt_a;
        logic    sign_ext;
        logic    reg_we;
        logic    dst_rt;
        wb_src_e wb_src;
        logic    mem_rd;
        logic    mem_wr;
        logic    beq;
        logic    bne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    ////////////////////////////////////////
    // funct codes for r-type
    ////////////////////////////////////////
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // instruction word layouts
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

// ==== hw/ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode
    import core_pkg::*, isa_pkg::*;
(
    input  instr_u i_instr,
    output ctrl_t  o_ctrl
);

    always_comb
    begin
        o_ctrl = '0;
        case (i_instr.r.op)
            OP_RTYPE:
            begin
                o_ctrl.reg_we  = 1'b1;
                // fixed shifts take shamt, the variable forms take rs
                o_ctrl.shamt_a = i_instr.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
                case (i_instr.r.funct)
                    FN_ADD, FN_ADDU:  o_ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU:  o_ctrl.alu_op = ALU_SUB;
                    FN_AND:           o_ctrl.alu_op = ALU_AND;
                    FN_OR:            o_ctrl.alu_op = ALU_OR;
                    FN_XOR:           o_ctrl.alu_op = ALU_XOR;
                    FN_NOR:           o_ctrl.alu_op = ALU_NOR;
                    FN_SLT:           o_ctrl.alu_op = ALU_SLT;
                    FN_SLTU:          o_ctrl.alu_op = ALU_SLTU;
                    FN_SLL, FN_SLLV:  o_ctrl.alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV:  o_ctrl.alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV:  o_ctrl.alu_op = ALU_SRA;
                    default:          o_ctrl = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                o_ctrl.reg_we   = 1'b1;
                o_ctrl.dst_rt   = 1'b1;
                o_ctrl.use_imm  = 1'b1;
                // logical immediates are zero extended
                o_ctrl.sign_ext = !(i_instr.i.op inside {OP_ANDI, OP_ORI, OP_XORI});
                case (i_instr.i.op)
                    OP_SLTI:  o_ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: o_ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  o_ctrl.alu_op = ALU_AND;
                    OP_ORI:   o_ctrl.alu_op = ALU_OR;
                    OP_XORI:  o_ctrl.alu_op = ALU_XOR;
                    OP_LUI:   o_ctrl.alu_op = ALU_LUI;
                    default:  o_ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW:
            begin
                o_ctrl.alu_op   = ALU_ADD;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.sign_ext = 1'b1;
                o_ctrl.reg_we   = 1'b1;
                o_ctrl.dst_rt   = 1'b1;
                o_ctrl.wb_src   = WB_MEM;
                o_ctrl.mem_rd   = 1'b1;
            end
            OP_SW:
            begin
                o_ctrl.alu_op   = ALU_ADD;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.sign_ext = 1'b1;
                o_ctrl.mem_wr   = 1'b1;
            end
            // branches compare rs and rt through the subtractor
            OP_BEQ:
            begin
                o_ctrl.alu_op = ALU_SUB;
                o_ctrl.beq    = 1'b1;
            end
            OP_BNE:
            begin
                o_ctrl.alu_op = ALU_SUB;
                o_ctrl.bne    = 1'b1;
            end
            OP_J:     o_ctrl.jump = 1'b1;
            default:  o_ctrl = '0;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t i_ra,
    input  reg_idx_t i_rb,
    output word_t    o_qa,
    output word_t    o_qb,
    input  logic     i_we,
    input  reg_idx_t i_wn,
    input  word_t    i_wd
);

    word_t regs [NUM_REGS];

    // register 0 reads as zero
    assign o_qa = (i_ra == '0) ? '0 : regs[i_ra];
    assign o_qb = (i_rb == '0) ? '0 : regs[i_rb];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_wn != '0))
        begin
            regs[i_wn] <= i_wd;
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  word_t   i_a,
    input  word_t   i_b,
    input  alu_op_e i_op,
    output word_t   o_result,
    output logic    o_zero
);

    logic [4:0] shamt;

    // only the low five bits of a shift amount count
    assign shamt = i_a[4:0];

    always_comb
    begin
        case (i_op)
            ALU_ADD:
                o_result = i_a + i_b;
            ALU_SUB:
                o_result = i_a - i_b;
            ALU_AND:
                o_result = i_a & i_b;
            ALU_OR:
                o_result = i_a | i_b;
            ALU_XOR:
                o_result = i_a ^ i_b;
            ALU_NOR:
                o_result = ~(i_a | i_b);
            ALU_SLT:
                o_result = {{(XLEN-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            ALU_SLTU:
                o_result = {{(XLEN-1){1'b0}}, (i_a < i_b)};
            ALU_SLL:
                o_result = i_b << shamt;
            ALU_SRL:
                o_result = i_b >> shamt;
            ALU_SRA:
                o_result = word_t'($signed(i_b) >>> shamt);
            // low half of b moves to the upper half
            ALU_LUI:
                o_result = {i_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            default:
                o_result = '0;
        endcase
    end

    // branch compare only
    assign o_zero = (o_result == '0);

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*, isa_pkg::*;
(
    input  instr_u    i_instr,
    input  ctrl_t     i_ctrl,
    output reg_idx_t  o_ra,
    output reg_idx_t  o_rb,
    input  word_t     i_qa,
    input  word_t     i_qb,
    output logic      o_rf_we,
    output reg_idx_t  o_rf_wn,
    output word_t     o_rf_wd,
    output dmem_req_t o_dmem_req,
    input  logic      i_dmem_ready,
    input  word_t     i_dmem_rdata,
    output logic      o_stall,
    output logic      o_zero
);

    word_t imm_ext;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  mem_access;

    assign o_ra = i_instr.r.rs;
    assign o_rb = i_instr.r.rt;

    ////////////////////////////////////////
    // operand selection
    ////////////////////////////////////////
    assign imm_ext = i_ctrl.sign_ext ? {{(XLEN-16){i_instr.i.imm[15]}}, i_instr.i.imm}
                                     : {{(XLEN-16){1'b0}}, i_instr.i.imm};
    assign alu_a   = i_ctrl.shamt_a ? {{(XLEN-5){1'b0}}, i_instr.r.shamt} : i_qa;
    assign alu_b   = i_ctrl.use_imm ? imm_ext : i_qb;

    alu alu_i (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_op     (i_ctrl.alu_op),
        .o_result (alu_result),
        .o_zero   (o_zero)
    );

    ////////////////////////////////////////
    // data memory handshake
    ////////////////////////////////////////
    assign mem_access = i_ctrl.mem_rd | i_ctrl.mem_wr;

    // request fields come straight from the held instruction
    assign o_dmem_req.valid = mem_access;
    assign o_dmem_req.write = i_ctrl.mem_wr;
    assign o_dmem_req.addr  = alu_result;
    assign o_dmem_req.wdata = i_qb;

    // wait here until the memory accepts
    assign o_stall = mem_access & ~i_dmem_ready;

    // write-back
    assign o_rf_we = i_ctrl.reg_we & ~o_stall;
    assign o_rf_wn = i_ctrl.dst_rt ? i_instr.r.rt : i_instr.r.rd;
    assign o_rf_wd = (i_ctrl.wb_src == WB_MEM) ? i_dmem_rdata : alu_result;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import core_pkg::*, isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  instr_u i_instr,
    input  ctrl_t  i_ctrl,
    input  logic   i_zero,
    input  logic   i_stall,
    output word_t  o_pc
);

    word_t pc;
    word_t pc_plus4;
    word_t br_target;
    word_t j_target;
    word_t next_pc;
    logic  br_taken;

    assign pc_plus4  = pc + word_t'(4);
    assign br_target = pc_plus4 + {{(XLEN-18){i_instr.i.imm[15]}}, i_instr.i.imm, 2'b00};
    // region bits kept from pc+4
    assign j_target  = {pc_plus4[XLEN-1:XLEN-4], i_instr.j.target, 2'b00};
    assign br_taken  = (i_ctrl.beq & i_zero) | (i_ctrl.bne & ~i_zero);

    assign next_pc = i_ctrl.jump ? j_target
                   : br_taken    ? br_target
                   : pc_plus4;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= '0;
        else if (!i_stall)
            pc <= next_pc;
    end

    assign o_pc = pc;

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import core_pkg::*, isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output word_t     o_imem_addr,
    input  instr_u    i_imem_instr,
    output dmem_req_t o_dmem_req,
    input  logic      i_dmem_ready,
    input  word_t     i_dmem_rdata
);

    ctrl_t    ctrl;
    reg_idx_t ra;
    reg_idx_t rb;
    word_t    qa;
    word_t    qb;
    logic     rf_we;
    reg_idx_t rf_wn;
    word_t    rf_wd;
    logic     stall;
    logic     zero;

    ctrl_decode ctrl_decode_i (
        .i_instr (i_imem_instr),
        .o_ctrl  (ctrl)
    );

    reg_file reg_file_i (
        .clk  (clk),
        .rst  (rst),
        .i_ra (ra),
        .i_rb (rb),
        .o_qa (qa),
        .o_qb (qb),
        .i_we (rf_we),
        .i_wn (rf_wn),
        .i_wd (rf_wd)
    );

    exec_unit exec_unit_i (
        .i_instr      (i_imem_instr),
        .i_ctrl       (ctrl),
        .o_ra         (ra),
        .o_rb         (rb),
        .i_qa         (qa),
        .i_qb         (qb),
        .o_rf_we      (rf_we),
        .o_rf_wn      (rf_wn),
        .o_rf_wd      (rf_wd),
        .o_dmem_req   (o_dmem_req),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata),
        .o_stall      (stall),
        .o_zero       (zero)
    );

    // pc drives the instruction port directly
    fetch_unit fetch_unit_i (
        .clk     (clk),
        .rst     (rst),
        .i_instr (i_imem_instr),
        .i_ctrl  (ctrl),
        .i_zero  (zero),
        .i_stall (stall),
        .o_pc    (o_imem_addr)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic o_clk
);

    // 100 ns period, low for the first half
    initial
    begin
        o_clk = 1'b0;
        forever
            #50 o_clk = ~o_clk;
    end

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
    import core_pkg::*, isa_pkg::*;
();

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    instr_u    imem_instr;
    dmem_req_t dmem_req;
    logic      dmem_ready;
    word_t     dmem_rdata;

    word_t       imem [256];
    word_t       dmem [256];
    int          rst_cnt;
    int          ready_wait;
    int          delay_pos;
    int unsigned delay_tab [64];
    int          errors;
    int          tests_run;
    logic        req_waiting;
    dmem_req_t   held_req;

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t log_addr [$];
    word_t log_data [$];

    tb_clk_gen clk_gen_i (
        .o_clk (clk)
    );

    cpu_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .o_imem_addr  (imem_addr),
        .i_imem_instr (imem_instr),
        .o_dmem_req   (dmem_req),
        .i_dmem_ready (dmem_ready),
        .i_dmem_rdata (dmem_rdata)
    );

    ////////////////////////////////////////
    // memory models
    ////////////////////////////////////////

    // reset sequencing and instruction fetch
    // nop words go out while reset is held
    always @(negedge clk)
    begin
        if (rst_cnt > 0)
        begin
            rst <= 1'b1;
            imem_instr <= '0;
            rst_cnt <= rst_cnt - 1;
        end
        else
        begin
            rst <= 1'b0;
            imem_instr <= imem[imem_addr[9:2]];
        end
    end

    // ready after 0 to 3 cycles
    // a new delay is drawn once the last request is done
    always @(negedge clk)
    begin
        if (rst || rst_cnt > 0)
        begin
            dmem_ready <= 1'b0;
            ready_wait = 0;
        end
        else if (dmem_ready || !dmem_req.valid)
        begin
            ready_wait = delay_tab[delay_pos];
            delay_pos = (delay_pos + 1) % 64;
            dmem_ready <= (ready_wait == 0);
        end
        else
        begin
            ready_wait = ready_wait - 1;
            dmem_ready <= (ready_wait <= 0);
        end
    end

    // read data only in the handshake cycle of a load
    assign dmem_rdata = (dmem_req.valid && dmem_ready && !dmem_req.write)
                      ? dmem[dmem_req.addr[9:2]] : 32'hdead_beef;

    // stores are written and logged in the handshake cycle
    always @(posedge clk)
    begin
        if (!rst && dmem_req.valid && dmem_ready && dmem_req.write)
        begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
            log_addr.push_back(dmem_req.addr);
            log_data.push_back(dmem_req.wdata);
        end
    end

    // a waiting request stays put until ready
    always @(posedge clk)
    begin
        if (rst)
        begin
            req_waiting = 1'b0;
        end
        else
        begin
            if (req_waiting)
            begin
                assert (dmem_req === held_req)
                else
                begin
                    $display("data memory request changed while ready was low: was %h, now %h",
                             held_req, dmem_req);
                    errors++;
                end
            end
            req_waiting = dmem_req.valid && !dmem_ready;
            held_req = dmem_req;
        end
    end

    ////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////
    function automatic word_t rtype(logic [5:0] funct, reg_idx_t rs, reg_idx_t rt,
                                    reg_idx_t rd, logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, funct};
    endfunction

    function automatic word_t itype(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // target is a word index
    function automatic word_t jump_to(logic [25:0] target);
        return {OP_J, target};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t val);
        emit(itype(OP_LUI, 0, rd, val[31:16]));
        emit(itype(OP_ORI, rd, rd, val[15:0]));
    endtask

    // sw rt, off(r0) and the store it should log
    task automatic store_word(input reg_idx_t rt, input logic [15:0] off, input word_t exp);
        emit(itype(OP_SW, 0, rt, off));
        exp_addr.push_back(word_t'(off));
        exp_data.push_back(exp);
    endtask

    task automatic begin_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        assert (act === exp)
        else
        begin
            $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // program run and store log compare
    ////////////////////////////////////////
    task automatic run_program(input string name);
        word_t halt_pc;
        int    cycles;
        bit    done;
        int    n;
        halt_pc = word_t'(prog.size() * 4);
        // parks the core at the end
        emit(jump_to(26'(prog.size())));
        @(posedge clk);
        rst_cnt = 16;
        @(negedge clk);
        for (int k = 0; k < 256; k++)
        begin
            imem[k] = (k < prog.size()) ? prog[k] : '0;
            dmem[k] <= 32'h5a00_0000 ^ (k * 32'h0001_0203);
        end
        log_addr.delete();
        log_data.delete();
        done = 1'b0;
        for (cycles = 0; cycles < 3000 && !done; cycles++)
        begin
            @(negedge clk);
            done = !rst && rst_cnt == 0 && imem_addr == halt_pc;
        end
        tests_run++;
        if (!done)
        begin
            $display("%s timed out, the program never reached its final jump", name);
            errors++;
        end
        else
        begin
            assert (log_addr.size() == exp_addr.size())
            else
            begin
                $display("%s logged %0d stores where %0d were expected", name,
                         log_addr.size(), exp_addr.size());
                errors++;
            end
            n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
            for (int i = 0; i < n; i++)
            begin
                check_word(name, $sformatf("store %0d addr", i), exp_addr[i], log_addr[i]);
                check_word(name, $sformatf("store %0d data", i), exp_data[i], log_data[i]);
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic arith_logic_ops();
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        a = $urandom();
        b = $urandom();
        imm = 16'($urandom());
        begin_program();
        load_const(1, a);
        load_const(2, b);
        emit(rtype(FN_ADD, 1, 2, 3, 0));
        emit(rtype(FN_ADDU, 1, 2, 4, 0));
        emit(rtype(FN_SUB, 1, 2, 5, 0));
        emit(rtype(FN_SUBU, 1, 2, 6, 0));
        emit(rtype(FN_AND, 1, 2, 7, 0));
        emit(rtype(FN_OR, 1, 2, 8, 0));
        emit(rtype(FN_XOR, 1, 2, 9, 0));
        emit(rtype(FN_NOR, 1, 2, 10, 0));
        emit(itype(OP_ADDI, 1, 11, imm));
        store_word(3, 16'h000, a + b);
        store_word(4, 16'h004, a + b);
        store_word(5, 16'h008, a - b);
        store_word(6, 16'h00c, a - b);
        store_word(7, 16'h010, a & b);
        store_word(8, 16'h014, a | b);
        store_word(9, 16'h018, a ^ b);
        store_word(10, 16'h01c, ~(a | b));
        store_word(11, 16'h020, a + {{16{imm[15]}}, imm});
        run_program("arith_logic");
    endtask

    task automatic shift_ops();
        word_t      v;
        word_t      amt;
        logic [4:0] sh;
        // negative value for sra and a variable amount above 31
        v = $urandom() | 32'h8000_0000;
        amt = $urandom_range(255, 32);
        sh = 5'($urandom_range(31, 1));
        begin_program();
        load_const(1, v);
        load_const(2, amt);
        emit(rtype(FN_SLL, 0, 1, 3, sh));
        emit(rtype(FN_SRL, 0, 1, 4, sh));
        emit(rtype(FN_SRA, 0, 1, 5, sh));
        emit(rtype(FN_SLLV, 2, 1, 6, 0));
        emit(rtype(FN_SRLV, 2, 1, 7, 0));
        emit(rtype(FN_SRAV, 2, 1, 8, 0));
        store_word(3, 16'h040, v << sh);
        store_word(4, 16'h044, v >> sh);
        store_word(5, 16'h048, word_t'($signed(v) >>> sh));
        store_word(6, 16'h04c, v << amt[4:0]);
        store_word(7, 16'h050, v >> amt[4:0]);
        store_word(8, 16'h054, word_t'($signed(v) >>> amt[4:0]));
        run_program("shifts");
    endtask

    task automatic compare_imm_ops();
        word_t pa [4] = '{32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0005};
        word_t pb [4] = '{32'h0000_0001, 32'h8000_0000, 32'h0000_0000, 32'h0000_0005};
        logic [15:0] off;
        begin_program();
        for (int k = 0; k < 4; k++)
        begin
            off = 16'h080 + 16'(k * 16);
            load_const(1, pa[k]);
            load_const(2, pb[k]);
            emit(rtype(FN_SLT, 1, 2, 3, 0));
            emit(rtype(FN_SLTU, 1, 2, 4, 0));
            emit(itype(OP_SLTI, 1, 5, 16'hffff));
            emit(itype(OP_SLTIU, 1, 6, 16'hffff));
            store_word(3, off, word_t'($signed(pa[k]) < $signed(pb[k])));
            store_word(4, off + 16'h4, word_t'(pa[k] < pb[k]));
            store_word(5, off + 16'h8, word_t'($signed(pa[k]) < -32'sd1));
            store_word(6, off + 16'hc, word_t'(pa[k] < 32'hffff_ffff));
        end
        // addi sign extends, the logical immediates do not
        emit(itype(OP_ADDI, 0, 1, 16'hffff));
        emit(itype(OP_LUI, 0, 7, 16'h1234));
        emit(itype(OP_ADDI, 0, 8, 16'h8001));
        emit(itype(OP_ANDI, 1, 9, 16'hf0f0));
        emit(itype(OP_ORI, 0, 10, 16'h8000));
        emit(itype(OP_XORI, 1, 11, 16'h8001));
        emit(itype(OP_ADDIU, 1, 12, 16'h0002));
        store_word(1, 16'h0c0, 32'hffff_ffff);
        store_word(7, 16'h0c4, 32'h1234_0000);
        store_word(8, 16'h0c8, 32'hffff_8001);
        store_word(9, 16'h0cc, 32'h0000_f0f0);
        store_word(10, 16'h0d0, 32'h0000_8000);
        store_word(11, 16'h0d4, 32'hffff_7ffe);
        store_word(12, 16'h0d8, 32'h0000_0001);
        run_program("compare_imm");
    endtask

    task automatic mem_backpressure();
        word_t w [4];
        begin_program();
        for (int k = 0; k < 4; k++)
        begin
            w[k] = $urandom();
            load_const(1, w[k]);
            store_word(1, 16'h100 + 16'(4 * k), w[k]);
        end
        for (int k = 0; k < 4; k++)
            emit(itype(OP_LW, 0, 5'(2 + k), 16'h100 + 16'(4 * k)));
        // copies go out through a base register
        emit(itype(OP_ADDI, 0, 9, 16'h200));
        for (int k = 0; k < 4; k++)
        begin
            emit(itype(OP_SW, 9, 5'(2 + k), 16'(4 * k)));
            exp_addr.push_back(32'h200 + 4 * k);
            exp_data.push_back(w[k]);
        end
        // load over its own base register then store it
        emit(itype(OP_LW, 9, 9, 16'h0008));
        store_word(9, 16'h220, w[2]);
        run_program("mem_backpressure");
    endtask

    task automatic control_flow();
        int jpos;
        begin_program();
        emit(itype(OP_ADDI, 0, 1, 16'd7));
        emit(itype(OP_ADDI, 0, 2, 16'd7));
        emit(itype(OP_ADDI, 0, 3, 16'd9));
        emit(itype(OP_BEQ, 1, 2, 16'd1));
        emit(itype(OP_SW, 0, 1, 16'h300));
        store_word(1, 16'h304, 32'd7);
        emit(itype(OP_BEQ, 1, 3, 16'd1));
        store_word(3, 16'h308, 32'd9);
        emit(itype(OP_BNE, 1, 3, 16'd1));
        emit(itype(OP_SW, 0, 3, 16'h30c));
        emit(itype(OP_BNE, 1, 2, 16'd1));
        store_word(2, 16'h310, 32'd7);
        // forward jump over one store
        jpos = prog.size();
        emit(jump_to(26'(jpos + 2)));
        emit(itype(OP_SW, 0, 2, 16'h314));
        emit(itype(OP_ADDI, 0, 0, 16'h0055));
        emit(rtype(FN_OR, 1, 3, 0, 0));
        store_word(0, 16'h318, 32'd0);
        run_program("control_flow");
    endtask

    initial
    begin
        rst = 1'b1;
        rst_cnt = 0;
        imem_instr = '0;
        dmem_ready = 1'b0;
        ready_wait = 0;
        delay_pos = 0;
        errors = 0;
        tests_run = 0;
        req_waiting = 1'b0;
        held_req = '0;
        void'($urandom(32'h9af9_3e00));
        for (int k = 0; k < 64; k++)
            delay_tab[k] = $urandom_range(3, 0);
        arith_logic_ops();
        shift_ops();
        compare_imm_ops();
        mem_backpressure();
        control_flow();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== files.f ====
hw/core_pkg.sv
hw/isa_pkg.sv
hw/ctrl_decode.sv
hw/reg_file.sv
hw/alu.sv
hw/exec_unit.sv
hw/fetch_unit.sv
hw/cpu_top.sv
sim/tb_clk_gen.sv
sim/cpu_tb.sv
